// ==== mem_acc_ctrl.sv ====
//============================================================
// permit or deny each request against its region level
// purely combinational, denied requests never wait on the bank
//============================================================

`timescale 1ns/1ps

`include "sec_mem_consts.svh"

module mem_acc_ctrl
	import sec_mem_pkg::*;
(
	// request from the network
	input  mem_req_ctrl_u                 net_req_ctrl,
	input  logic                          net_req_sec_level,
	input  logic                          net_req_val,
	output logic                          net_req_rdy,

	// required levels from the table
	input  logic [`SM_REGIONS-1:0]        region_levels,

	// request side of the bank
	output logic                          bank_req_val,
	input  logic                          bank_req_rdy,

	// denial report to the log
	output logic                          deny_fire,
	output logic [`SM_ADDR_W-1:0]         deny_addr
);

	logic [`SM_REGION_W-1:0]  req_region;
	logic                     req_level_needed;
	logic                     permit;

	//============================================================
	// access check
	//============================================================

	// region tag comes from the security view of the word
	assign req_region       = net_req_ctrl.sec.region;
	assign req_level_needed = region_levels[req_region];

	// permitted when the request level is at least the region level
	assign permit = (net_req_sec_level >= req_level_needed);

	//============================================================
	// handshake steering
	//============================================================

	// only permitted traffic reaches the bank
	// valid is never a function of ready here
	assign bank_req_val = net_req_val & permit;

	// a denied request is swallowed in its first cycle,
	// permitted ones wait on the bank
	assign net_req_rdy = permit ? bank_req_rdy : 1'b1;

	// denied and valid means consumed this edge
	assign deny_fire = net_req_val & ~permit;

	// full byte address rebuilt from region and offset
	assign deny_addr = {net_req_ctrl.sec.region, net_req_ctrl.sec.offset};

endmodule

// ==== mem_bank.sv ====
//============================================================
// single ported word memory, one response in flight at most
// upper address bits alias, only the word index is decoded
//============================================================

`timescale 1ns/1ps

`include "sec_mem_consts.svh"

module mem_bank
	import sec_mem_pkg::*;
(
	input  logic                      clk,
	input  logic                      arst_n,

	// request from the access controller
	input  mem_req_ctrl_u             bank_req_ctrl,
	input  logic [`SM_DATA_W-1:0]     bank_req_data,
	input  logic                      bank_req_val,
	output logic                      bank_req_rdy,

	// response straight to the network
	output mem_resp_msg_t             net_resp_ctrl,
	output logic [`SM_DATA_W-1:0]     net_resp_data,
	output logic                      net_resp_val,
	input  logic                      net_resp_rdy
);

	// storage, contents are not reset
	logic [`SM_DATA_W-1:0]     mem [0:`SM_MEM_WORDS-1];

	logic                      req_fire;
	logic                      req_is_write;
	logic [`SM_WORD_IDX_W-1:0] word_idx;

	//============================================================
	// request decode
	//============================================================

	// the bank reads the message view of the union
	assign word_idx     = bank_req_ctrl.msg.addr[`SM_BYTE_OFF_W +: `SM_WORD_IDX_W];
	// anything that is not a write is served as a read
	assign req_is_write = (bank_req_ctrl.msg.msg_type == MEM_WRITE);

	// room when empty or when the held response leaves this edge
	assign bank_req_rdy = ~net_resp_val | net_resp_rdy;
	assign req_fire     = bank_req_val & bank_req_rdy;

	//============================================================
	// storage array
	//============================================================

	always_ff @(posedge clk) begin
		if (req_fire && req_is_write) begin
			mem[word_idx] <= bank_req_data;
		end
	end

	//============================================================
	// response register
	//============================================================

	// valid bit, the only control state in the bank
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			net_resp_val <= 1'b0;
		end else if (req_fire) begin
			net_resp_val <= 1'b1;
		end else if (net_resp_rdy) begin
			// drained with nothing new behind it
			net_resp_val <= 1'b0;
		end
	end

	// payload only loads on accept, so it holds under back-pressure
	always_ff @(posedge clk) begin
		if (req_fire) begin
			net_resp_ctrl.msg_type <= bank_req_ctrl.msg.msg_type;
			net_resp_ctrl.opaque   <= bank_req_ctrl.msg.opaque;
			net_resp_ctrl.len      <= bank_req_ctrl.msg.len;
			// writes answer with zero data
			net_resp_data          <= req_is_write ? '0 : mem[word_idx];
		end
	end

endmodule

// ==== project.f ====
+incdir+.
sec_mem_pkg.sv
sec_level_table.sv
mem_acc_ctrl.sv
mem_bank.sv
violation_log.sv
sec_mem_top.sv
sec_mem_checker.sv
sec_mem_tb.sv

// ==== run.sh ====
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module sec_mem_tb -f project.f -o sec_mem_sim \
	|| exit 1
out="$(./obj_dir/sec_mem_sim)"
echo "$out"
echo "$out" | grep -qF '*** PASSED ***' && exit 0 || exit 1

// ==== sec_level_table.sv ====
//============================================================
// required security level per address region
// all regions reset to low, so the port starts fully open
//============================================================

`timescale 1ns/1ps

`include "sec_mem_consts.svh"

module sec_level_table (
	input  logic                      clk,
	input  logic                      arst_n,

	// configuration strobe, one region per cycle
	input  logic                      cfg_val,
	input  logic [`SM_REGION_W-1:0]   cfg_region,
	input  logic                      cfg_level,

	// one required level bit per region
	output logic [`SM_REGIONS-1:0]    region_levels
);

	//============================================================
	// level registers
	//============================================================

	// a strobe lands on the next edge and is visible the cycle after
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			// every region open after reset
			region_levels <= {`SM_REGIONS{`SM_LEVEL_LOW}};
		end else if (cfg_val) begin
			// only the selected entry changes
			region_levels[cfg_region] <= cfg_level;
		end
	end

endmodule

// ==== sec_mem_checker.sv ====
//============================================================
// handshake and security rules, bound into the top level
// all rules sample on the rising clock edge
//============================================================

`timescale 1ns/1ps

`include "sec_mem_consts.svh"

module sec_mem_checker
	import sec_mem_pkg::*;
(
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    bank_req_val,
	input  logic                    bank_req_rdy,
	input  mem_resp_msg_t           net_resp_ctrl,
	input  logic [`SM_DATA_W-1:0]   net_resp_data,
	input  logic                    net_resp_val,
	input  logic                    net_resp_rdy,
	input  logic                    deny_fire,
	input  logic                    viol_alarm
);

	//============================================================
	// response path
	//============================================================

	// a held response keeps valid and payload
	assert property (@(posedge clk) disable iff (!arst_n)
		net_resp_val && !net_resp_rdy |=>
			net_resp_val && $stable(net_resp_data) && $stable(net_resp_ctrl))
		else $error("response changed while stalled");

	// a fresh response needs a bank accept on the edge before
	assert property (@(posedge clk) disable iff (!arst_n)
		net_resp_val && !($past(net_resp_val) && !$past(net_resp_rdy)) |->
			$past(bank_req_val && bank_req_rdy))
		else $error("response without a permitted accept");

	// nothing in flight while reset is applied
	assert property (@(posedge clk) !arst_n |-> !net_resp_val)
		else $error("response valid during reset");

	//============================================================
	// violation log
	//============================================================

	// alarm only follows a consumed denial
	assert property (@(posedge clk) disable iff (!arst_n)
		viol_alarm |-> $past(deny_fire))
		else $error("alarm without a denial");

endmodule

bind sec_mem_top sec_mem_checker u_checker (
	.clk           (clk),
	.arst_n        (arst_n),
	.bank_req_val  (bank_req_val),
	.bank_req_rdy  (bank_req_rdy),
	.net_resp_ctrl (net_resp_ctrl),
	.net_resp_data (net_resp_data),
	.net_resp_val  (net_resp_val),
	.net_resp_rdy  (net_resp_rdy),
	.deny_fire     (deny_fire),
	.viol_alarm    (viol_alarm)
);

// ==== sec_mem_consts.svh ====
//============================================================
// widths and sizes shared by the secure memory port
// the region tag is the top SM_REGION_W address bits
//============================================================

`ifndef SEC_MEM_CONSTS_SVH
`define SEC_MEM_CONSTS_SVH

// message field widths
`define SM_DATA_W      32
`define SM_ADDR_W      32
`define SM_OPAQUE_W    8
`define SM_TYPE_W      3
`define SM_LEN_W       2

// bank geometry, word index sits just above the byte offset
`define SM_MEM_WORDS   256
`define SM_WORD_IDX_W  8
`define SM_BYTE_OFF_W  2

// address regions, one required level each
`define SM_REGION_W    4
`define SM_REGIONS     16

// security levels, high may touch everything
`define SM_LEVEL_LOW   1'b0
`define SM_LEVEL_HIGH  1'b1

// violation counter width
`define SM_VIOL_CNT_W  16

`endif

// ==== sec_mem_pkg.sv ====
//============================================================
// message types for the secure memory port
// both request views are 45 bits and overlay one word
//============================================================

`include "sec_mem_consts.svh"

package sec_mem_pkg;

	// message type, only read and write are served
	typedef enum logic [`SM_TYPE_W-1:0] {
		MEM_READ  = 3'd0,
		MEM_WRITE = 3'd1
	} mem_type_e;

	// request control as the bank decodes it
	typedef struct packed {
		mem_type_e                msg_type;
		logic [`SM_OPAQUE_W-1:0]  opaque;
		logic [`SM_ADDR_W-1:0]    addr;
		logic [`SM_LEN_W-1:0]     len;
	} mem_req_msg_t;

	// same bits as the access check decodes them
	// prefix covers type and opaque, region is the top of the address
	typedef struct packed {
		logic [`SM_TYPE_W+`SM_OPAQUE_W-1:0]     prefix;
		logic [`SM_REGION_W-1:0]                region;
		logic [`SM_ADDR_W-`SM_REGION_W-1:0]     offset;
		logic [`SM_LEN_W-1:0]                   len;
	} mem_req_sec_t;

	// one request word, two readings
	typedef union packed {
		mem_req_msg_t  msg;
		mem_req_sec_t  sec;
	} mem_req_ctrl_u;

	// response control, data travels on its own port
	typedef struct packed {
		mem_type_e                msg_type;
		logic [`SM_OPAQUE_W-1:0]  opaque;
		logic [`SM_LEN_W-1:0]     len;
	} mem_resp_msg_t;

endpackage

// ==== sec_mem_tb.sv ====
//============================================================
// directed and random traffic against a word and level model
// only word indices 0..15 are read, all written by the first test
//============================================================

`timescale 1ns/1ps

`include "sec_mem_consts.svh"

module sec_mem_tb
	import sec_mem_pkg::*;
();

	// request budget per test, in test order
	localparam int TOTAL_REQS = 32 + 2 + 5 + 2 + 200;
	localparam int TIMEOUT_CYCLES = TOTAL_REQS * 4 + 10 + 200;

	// clock and reset
	logic clk;
	logic arst_n;

	// request side
	mem_req_ctrl_u req;
	logic [31:0] req_data;
	logic req_lvl;
	logic req_val;
	logic req_rdy;

	// response side
	mem_resp_msg_t resp_ctrl;
	logic [31:0] resp_data;
	logic resp_val;
	logic resp_rdy;

	// region config and violation log
	logic cfg_val;
	logic [3:0] cfg_region;
	logic cfg_level;
	logic alarm;
	logic [15:0] count;
	logic [31:0] viol_addr;

	// reference model
	logic [31:0] model_mem [0:255];
	logic [15:0] model_levels;
	logic [15:0] exp_viol;
	logic [40:0] exp_q [$];
	logic [40:0] exp_resp;
	mem_type_e exp_type;
	logic [7:0] tag_ctr;

	// stimulus and bookkeeping
	logic rand_ready;
	logic run_closed;
	logic [31:0] rnd;
	logic [31:0] rdy_rnd;
	string test_name;
	int errors;
	int err_start;
	int tests;
	int failed_tests;
	int cycles;

	sec_mem_top uut (
		.clk               (clk),
		.arst_n            (arst_n),
		.net_req_ctrl      (req),
		.net_req_data      (req_data),
		.net_req_sec_level (req_lvl),
		.net_req_val       (req_val),
		.net_req_rdy       (req_rdy),
		.net_resp_ctrl     (resp_ctrl),
		.net_resp_data     (resp_data),
		.net_resp_val      (resp_val),
		.net_resp_rdy      (resp_rdy),
		.cfg_val           (cfg_val),
		.cfg_region        (cfg_region),
		.cfg_level         (cfg_level),
		.viol_alarm        (alarm),
		.viol_count        (count),
		.viol_addr         (viol_addr)
	);

	always #2 clk = ~clk;

	// run limit from the request budget
	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout, run stopped after %0d cycles", cycles);
			run_closed = 1'b1;
			$display("*** FAILED ***");
			$finish;
		end
	end

	task automatic check(input string what, input logic [31:0] expv, input logic [31:0] actv);
		assert (expv === actv) else begin
			errors++;
			$display("ERR %s %s expected %h actual %h", test_name, what, expv, actv);
		end
	endtask

	// random response back-pressure with ready three times in four
	always @(negedge clk) begin
		if (rand_ready) begin
			rdy_rnd = $urandom;
			resp_rdy = rdy_rnd[0] | rdy_rnd[1];
		end
	end

	// response monitor samples just after the falling edge
	// the handshake itself lands on the next rising edge
	always @(negedge clk) begin
		#1;
		if (arst_n && resp_val && resp_rdy) begin
			assert (exp_q.size() != 0) else begin
				errors++;
				$display("%s: response arrived with none outstanding", test_name);
			end
			if (exp_q.size() != 0) begin
				exp_resp = exp_q.pop_front();
				exp_type = exp_resp[40] ? MEM_WRITE : MEM_READ;
				check("resp type", {29'd0, exp_type}, {29'd0, resp_ctrl.msg_type});
				check("resp opaque", {24'd0, exp_resp[39:32]}, {24'd0, resp_ctrl.opaque});
				// single word requests only, so len returns as zero
				check("resp len", 32'd0, {30'd0, resp_ctrl.len});
				check("resp data", exp_resp[31:0], resp_data);
			end
		end
	end

	task automatic set_level(input logic [3:0] region, input logic lvl);
		@(negedge clk);
		cfg_val = 1'b1;
		cfg_region = region;
		cfg_level = lvl;
		@(negedge clk);
		cfg_val = 1'b0;
		model_levels[region] = lvl;
	endtask

	// one request with the model updated at its accept
	task automatic do_req(input logic wr, input logic [3:0] region, input logic [7:0] idx,
			input logic [31:0] wdata, input logic lvl);
		logic deny;
		logic [31:0] addr;
		addr = {region, 18'd0, idx, 2'b00};
		// permitted only when the request level reaches the region level
		deny = lvl < model_levels[region];
		@(negedge clk);
		req.msg.msg_type = wr ? MEM_WRITE : MEM_READ;
		req.msg.opaque = tag_ctr;
		req.msg.addr = addr;
		req.msg.len = 2'd0;
		req_data = wdata;
		req_lvl = lvl;
		req_val = 1'b1;
		#1;
		// denial must not wait on the bank
		if (deny)
			check("deny rdy", 32'd1, {31'd0, req_rdy});
		while (!req_rdy) begin
			@(negedge clk);
			#1;
		end
		if (deny) begin
			exp_viol++;
		end else begin
			// read data is the word before any write on this edge
			exp_q.push_back({wr, tag_ctr, wr ? 32'd0 : model_mem[idx]});
			if (wr)
				model_mem[idx] = wdata;
		end
		tag_ctr++;
		@(negedge clk);
		req_val = 1'b0;
		if (deny) begin
			#1;
			check("alarm", 32'd1, {31'd0, alarm});
			check("viol_count", {16'd0, exp_viol}, {16'd0, count});
			check("viol_addr", addr, viol_addr);
			@(negedge clk);
			#1;
			check("alarm pulse", 32'd0, {31'd0, alarm});
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		err_start = errors;
	endtask

	// drain and then look for stray responses
	task automatic end_test();
		@(negedge clk);
		rand_ready = 1'b0;
		resp_rdy = 1'b1;
		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (3) @(negedge clk);
		check("viol_count", {16'd0, exp_viol}, {16'd0, count});
		tests++;
		if (errors != err_start)
			failed_tests++;
		$display("test %s: %s", test_name, (errors == err_start) ? "ok" : "failed");
	endtask

	initial begin
		void'($urandom(32347));
		clk = 1'b0;
		arst_n = 1'b0;
		req_lvl = 1'b0;
		req_val = 1'b0;
		cfg_val = 1'b0;
		cfg_level = 1'b0;
		rand_ready = 1'b0;
		run_closed = 1'b0;
		req = '0;
		req_data = '0;
		resp_rdy = 1'b1;
		cfg_region = '0;
		model_levels = '0;
		exp_viol = '0;
		tag_ctr = '0;
		repeat (10) @(negedge clk);
		arst_n = 1'b1;

		start_test("open_region");
		for (int i = 0; i < 16; i++)
			do_req(1'b1, 4'd0, i[7:0], $urandom, 1'b0);
		for (int i = 0; i < 16; i++)
			do_req(1'b0, 4'd0, i[7:0], 32'd0, 1'b0);
		end_test();

		// bank busy with a held response while the denial arrives
		start_test("denial");
		set_level(4'd3, 1'b1);
		@(negedge clk);
		resp_rdy = 1'b0;
		do_req(1'b0, 4'd0, 8'd2, 32'd0, 1'b0);
		do_req(1'b0, 4'd3, 8'd4, 32'd0, 1'b0);
		end_test();

		// denied write in the middle must leave word 5 alone
		start_test("permission");
		do_req(1'b1, 4'd3, 8'd5, 32'h1234_5678, 1'b1);
		do_req(1'b1, 4'd3, 8'd5, 32'hdead_beef, 1'b0);
		do_req(1'b0, 4'd3, 8'd5, 32'd0, 1'b1);
		do_req(1'b0, 4'd1, 8'd5, 32'd0, 1'b0);
		do_req(1'b0, 4'd1, 8'd6, 32'd0, 1'b1);
		end_test();

		// first read is held while a second one waits behind it
		start_test("backpressure");
		@(negedge clk);
		resp_rdy = 1'b0;
		do_req(1'b0, 4'd0, 8'd1, 32'd0, 1'b0);
		req.msg.msg_type = MEM_READ;
		req.msg.opaque = tag_ctr;
		req.msg.addr = {4'd0, 18'd0, 8'd2, 2'b00};
		req_lvl = 1'b0;
		req_val = 1'b1;
		#1;
		repeat (4) begin
			check("req rdy stalled", 32'd0, {31'd0, req_rdy});
			check("held valid", 32'd1, {31'd0, resp_val});
			check("held opaque", {24'd0, tag_ctr - 8'd1}, {24'd0, resp_ctrl.opaque});
			check("held data", model_mem[1], resp_data);
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		resp_rdy = 1'b1;
		#1;
		check("req rdy drained", 32'd1, {31'd0, req_rdy});
		exp_q.push_back({1'b0, tag_ctr, model_mem[2]});
		tag_ctr++;
		@(negedge clk);
		req_val = 1'b0;
		end_test();

		start_test("random_mix");
		set_level(4'd5, 1'b1);
		set_level(4'd9, 1'b1);
		rand_ready = 1'b1;
		for (int i = 0; i < 200; i++) begin
			rnd = $urandom;
			do_req(rnd[0], rnd[4:1], {4'd0, rnd[8:5]}, $urandom, rnd[9]);
		end
		end_test();

		$display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
		run_closed = 1'b1;
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// a run stopped by a bound assertion ends here
	final begin
		if (!run_closed)
			$display("*** FAILED ***");
	end

endmodule

// ==== sec_mem_top.sv ====
//============================================================
// secure memory port, region table in front of one bank
// responses pass unchecked since only permitted requests hit the bank
//============================================================

`timescale 1ns/1ps

`include "sec_mem_consts.svh"

module sec_mem_top
	import sec_mem_pkg::*;
(
	input  logic                        clk,
	input  logic                        arst_n,

	// request from the network
	input  mem_req_ctrl_u               net_req_ctrl,
	input  logic [`SM_DATA_W-1:0]       net_req_data,
	input  logic                        net_req_sec_level,
	input  logic                        net_req_val,
	output logic                        net_req_rdy,

	// response to the network
	output mem_resp_msg_t               net_resp_ctrl,
	output logic [`SM_DATA_W-1:0]       net_resp_data,
	output logic                        net_resp_val,
	input  logic                        net_resp_rdy,

	// region level configuration
	input  logic                        cfg_val,
	input  logic [`SM_REGION_W-1:0]     cfg_region,
	input  logic                        cfg_level,

	// violation log
	output logic                        viol_alarm,
	output logic [`SM_VIOL_CNT_W-1:0]   viol_count,
	output logic [`SM_ADDR_W-1:0]       viol_addr
);

	logic [`SM_REGIONS-1:0]  region_levels;
	logic                    bank_req_val;
	logic                    bank_req_rdy;
	logic                    deny_fire;
	logic [`SM_ADDR_W-1:0]   deny_addr;

	//============================================================
	// security path
	//============================================================

	sec_level_table u_table (
		.clk           (clk),
		.arst_n        (arst_n),
		.cfg_val       (cfg_val),
		.cfg_region    (cfg_region),
		.cfg_level     (cfg_level),
		.region_levels (region_levels)
	);

	mem_acc_ctrl u_ctrl (
		.net_req_ctrl      (net_req_ctrl),
		.net_req_sec_level (net_req_sec_level),
		.net_req_val       (net_req_val),
		.net_req_rdy       (net_req_rdy),
		.region_levels     (region_levels),
		.bank_req_val      (bank_req_val),
		.bank_req_rdy      (bank_req_rdy),
		.deny_fire         (deny_fire),
		.deny_addr         (deny_addr)
	);

	violation_log u_log (
		.clk        (clk),
		.arst_n     (arst_n),
		.deny_fire  (deny_fire),
		.deny_addr  (deny_addr),
		.viol_alarm (viol_alarm),
		.viol_count (viol_count),
		.viol_addr  (viol_addr)
	);

	//============================================================
	// memory path
	//============================================================

	// ctrl and data go to the bank as they arrive, valid is gated
	mem_bank u_bank (
		.clk           (clk),
		.arst_n        (arst_n),
		.bank_req_ctrl (net_req_ctrl),
		.bank_req_data (net_req_data),
		.bank_req_val  (bank_req_val),
		.bank_req_rdy  (bank_req_rdy),
		.net_resp_ctrl (net_resp_ctrl),
		.net_resp_data (net_resp_data),
		.net_resp_val  (net_resp_val),
		.net_resp_rdy  (net_resp_rdy)
	);

endmodule

// ==== violation_log.sv ====
//============================================================
// denied access log, count saturates at all ones
// alarm is one cycle per denial, back to back denials stay high
//============================================================

`timescale 1ns/1ps

`include "sec_mem_consts.svh"

module violation_log (
	input  logic                        clk,
	input  logic                        arst_n,

	// denial report from the controller
	input  logic                        deny_fire,
	input  logic [`SM_ADDR_W-1:0]       deny_addr,

	// log outputs
	output logic                        viol_alarm,
	output logic [`SM_VIOL_CNT_W-1:0]   viol_count,
	output logic [`SM_ADDR_W-1:0]       viol_addr
);

	//============================================================
	// alarm and counter
	//============================================================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			viol_alarm <= 1'b0;
			viol_count <= '0;
		end else begin
			// pulse follows the denial by one cycle
			viol_alarm <= deny_fire;
			// hold at the top instead of wrapping
			if (deny_fire && (viol_count != '1)) begin
				viol_count <= viol_count + 1'b1;
			end
		end
	end

	// last denied address, updates on the same edge as the count
	always_ff @(posedge clk) begin
		if (deny_fire) begin
			viol_addr <= deny_addr;
		end
	end

endmodule
